// ==== sim/video_cases.txt ====
# prog region offset data | wvram and wobj addr data | rvram and robj addr expected byte
# set flip pal_sel gfx_en | pix x y red green blue | all values hex
prog 0 05 12
prog 1 05 03
prog 0 25 45
prog 1 25 06
prog 0 19 9a
prog 1 19 0b
prog 2 53 05
prog 2 66 05
prog 2 89 05
prog 3 51 09
prog 3 93 0c
prog 3 64 00
prog 3 a6 00
prog 3 49 0c
wvram 1 01
wvram 5 82
wobj 0 01
wobj 1 0a
wobj 2 01
wobj 3 00
wobj 4 01
wobj 5 08
wobj 6 02
wobj 7 00
wobj 8 01
wobj 9 08
wobj a 01
wobj b 08
wobj c 00
rvram 5 82
robj 1 0a
robj 6 02
robj b 08
set 0 0 1
pix 0b 02 1 2 3
set 0 1 1
pix 0b 02 4 5 6
set 0 0 3
pix 0b 02 9 a b
pix 0e 04 1 2 3
pix 09 09 1 2 3
set 1 0 3
pix 14 1d 9 a b
set 1 0 1
pix 14 1d 1 2 3

// ==== list.f ====
design/mikie_video_pkg.sv
design/video_timer.sv
design/tile_layer.sv
design/sprite_layer.sv
design/color_mixer.sv
design/mikie_video.sv
sim/mikie_video_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mikie_video_tb \
    -Mdir obj_dir -f list.f \
    && out=$(./obj_dir/Vmikie_video_tb) || { echo "$out"; exit 1; }
echo "$out"
grep -q '\*\*\* PASSED \*\*\*' <<< "$out" && exit 0 || exit 1

// ==== sim/mikie_video_tb.sv ====
`timescale 1ns/1ps

module mikie_video_tb;
    import mikie_video_pkg::*;

    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL * 2;  // One pixel every other clk

    logic           clk;
    logic           rst_n;
    logic           pxl_cen;
    logic           flip;
    logic           pal_sel;
    logic [1:0]     gfx_en;
    cpu_bus_t       cpu;
    logic           vram_cs;
    logic           objram_cs;
    logic [7:0]     vram_dout;
    logic [7:0]     obj_dout;
    prog_bus_t      prog;
    logic           hs;
    logic           vs;
    logic           lhbl;
    logic           lvbl;
    rgb_t           rgb;

    int             value_errs = 0;
    int             other_errs = 0;
    int             cycles = 0;
    int             limit = 0;
    int             fd;
    int             n_lines = 0;
    int             n_pix = 0;
    logic [63:0]    cmd;
    logic [1023:0]  rest_of_line;

    // Screen position rebuilt from the delayed blanking
    int             sx = 0;
    int             sy = -1;
    int             frame_no = 0;
    int             lines_cnt = 0;
    int             lines_per_frame = 0;
    int             vis_cnt = 0;
    int             vis_per_line = 0;
    logic           prev_lhbl = 1'b0;
    logic           prev_lvbl = 1'b0;
    logic           prev_hs = 1'b0;
    logic           prev_vs = 1'b0;

    mikie_video uut(
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .flip      ( flip      ),
        .pal_sel   ( pal_sel   ),
        .gfx_en    ( gfx_en    ),
        .cpu       ( cpu       ),
        .vram_cs   ( vram_cs   ),
        .objram_cs ( objram_cs ),
        .vram_dout ( vram_dout ),
        .obj_dout  ( obj_dout  ),
        .prog      ( prog      ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .rgb       ( rgb       )
    );

    always #5 clk = ~clk;

    always @(negedge clk) pxl_cen <= ~pxl_cen;

    // Old pxl_cen high here means the last posedge moved the outputs
    always @(negedge clk) begin
        if (rst_n && pxl_cen) begin
            if (lhbl && !prev_lhbl) begin
                sx = 0;
                vis_cnt = 0;
                if (lvbl) begin
                    sy = sy + 1;
                    if (sy == 0) frame_no = frame_no + 1;
                end
            end else begin
                sx = sx + 1;
            end
            if (lhbl) vis_cnt = vis_cnt + 1;
            if (!lhbl && prev_lhbl) vis_per_line = vis_cnt;
            if (!lvbl && prev_lvbl) sy = -1;    // Wait for the next first line
            if (hs && !prev_hs) lines_cnt = lines_cnt + 1;
            if (vs && !prev_vs) begin
                lines_per_frame = lines_cnt;
                lines_cnt = 0;
            end
            prev_lhbl = lhbl;
            prev_lvbl = lvbl;
            prev_hs   = hs;
            prev_vs   = vs;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d clock cycles, the raster never reached a check", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns %s: expected %0h, got %0h", $time, name, exp, got);
            value_errs++;
        end
    endtask

    task automatic load_table(input int region, input int offset, input int data);
        @(negedge clk);
        prog <= '{region: 3'(region), offset: 8'(offset), data: 8'(data), we: 1'b1};
        @(negedge clk);
        prog.we <= 1'b0;
    endtask

    task automatic cpu_access(input bit is_obj, input bit rd, input int address,
                              input int data);
        @(negedge clk);
        cpu       <= '{addr: 11'(address), dout: 8'(data), rnw: rd};
        vram_cs   <= !is_obj;
        objram_cs <= is_obj;
        @(negedge clk);
        vram_cs   <= 1'b0;
        objram_cs <= 1'b0;
        cpu.rnw   <= 1'b1;
        if (rd) begin
            // Byte captured at the posedge in between
            expect_eq(is_obj ? "obj_dout" : "vram_dout", is_obj ? obj_dout : vram_dout, data);
        end
    endtask

    task automatic check_pixel(input int x, input int y, input int r, input int g, input int b);
        int start;
        @(posedge clk);
        start = frame_no;
        while (!(frame_no != start && sx == x && sy == y)) @(posedge clk);
        expect_eq($sformatf("rgb at (%0d,%0d)", x, y), rgb, {4'(r), 4'(g), 4'(b)});
    endtask

    task automatic count_cases();
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd != "#") n_lines++;
            if (cmd == "pix") n_pix++;
            void'($fgets(rest_of_line, fd));
        end
    endtask

    task automatic run_cases();
        int a;
        int b;
        int c;
        int d;
        int e;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "prog" && $fscanf(fd, "%h %h %h", a, b, c) == 3) begin
                load_table(a, b, c);
            end else if (cmd == "wvram" && $fscanf(fd, "%h %h", a, b) == 2) begin
                cpu_access(1'b0, 1'b0, a, b);
            end else if (cmd == "wobj" && $fscanf(fd, "%h %h", a, b) == 2) begin
                cpu_access(1'b1, 1'b0, a, b);
            end else if (cmd == "rvram" && $fscanf(fd, "%h %h", a, b) == 2) begin
                cpu_access(1'b0, 1'b1, a, b);
            end else if (cmd == "robj" && $fscanf(fd, "%h %h", a, b) == 2) begin
                cpu_access(1'b1, 1'b1, a, b);
            end else if (cmd == "set" && $fscanf(fd, "%h %h %h", a, b, c) == 3) begin
                @(negedge clk);
                flip    <= a[0];
                pal_sel <= b[0];
                gfx_en  <= c[1:0];
            end else if (cmd == "pix" && $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e) == 5) begin
                check_pixel(a, b, c, d, e);
            end else if (cmd != "#") begin
                $display("Case file line starting with '%0s' could not be read", cmd);
                other_errs++;
            end
            void'($fgets(rest_of_line, fd));
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        flip      = 1'b0;
        pal_sel   = 1'b0;
        gfx_en    = 2'b11;
        cpu       = '{addr: '0, dout: '0, rnw: 1'b1};
        vram_cs   = 1'b0;
        objram_cs = 1'b0;
        prog      = '0;
        repeat (4) @(negedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        expect_eq("hs", hs, 0);
        expect_eq("vs", vs, 0);
        expect_eq("rgb", rgb, 0);
        expect_eq("lhbl", lhbl, 0);
        expect_eq("lvbl", lvbl, 0);

        fd = $fopen("sim/video_cases.txt", "r");
        if (fd == 0) begin
            $display("Case file sim/video_cases.txt could not be opened");
            other_errs++;
        end else begin
            count_cases();
            $fclose(fd);
            // Each pixel check may span up to two frames, plus three for timing
            limit = (2 * n_pix + 3 + 2) * FRAME_CLKS + n_lines * 4;
            while (frame_no < 3) @(posedge clk);
            expect_eq("lines per frame", lines_per_frame, V_TOTAL);
            expect_eq("visible pixels per line", vis_per_line, H_ACTIVE);
            fd = $fopen("sim/video_cases.txt", "r");
            run_cases();
            $fclose(fd);
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== design/mikie_video.sv ====
`timescale 1ns/1ps

module mikie_video(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_cen,
    input  logic                       flip,
    input  logic                       pal_sel,
    input  logic [1:0]                 gfx_en,
    input  mikie_video_pkg::cpu_bus_t  cpu,
    input  logic                       vram_cs,
    input  logic                       objram_cs,
    output logic [7:0]                 vram_dout,
    output logic [7:0]                 obj_dout,
    input  mikie_video_pkg::prog_bus_t prog,
    output logic                       hs,
    output logic                       vs,
    output logic                       lhbl,
    output logic                       lvbl,
    output mikie_video_pkg::rgb_t      rgb
);
    import mikie_video_pkg::*;

    raster_t    raster;
    pxl_t       tile_pxl;
    pxl_t       obj_pxl;
    logic       tile_prio;
    logic [3:0] prog_we;    // One-hot, one per loadable table
    logic [1:0] fix_addr;
    cpu_bus_t   obj_cpu;

    always_comb begin
        prog_we = '0;
        prog_we[prog.region[1:0]] = prog.we && !prog.region[2]; // Upper regions unused
    end

    // CPU order attr, x, code, y becomes y, attr, code, x
    always_comb begin
        case (cpu.addr[1:0])
            2'd0:    fix_addr = 2'd1;  // attr
            2'd1:    fix_addr = 2'd3;  // x
            2'd2:    fix_addr = 2'd2;  // code
            default: fix_addr = 2'd0;  // y
        endcase
        obj_cpu = cpu;
        obj_cpu.addr[1:0] = fix_addr;
    end

    video_timer u_timer(
        .clk     ( clk       ),
        .rst_n   ( rst_n     ),
        .pxl_cen ( pxl_cen   ),
        .raster  ( raster    ),
        .hs      ( hs        ),
        .vs      ( vs        )
    );

    tile_layer u_tile(
        .clk       ( clk                    ),
        .rst_n     ( rst_n                  ),
        .pxl_cen   ( pxl_cen                ),
        .flip      ( flip                   ),
        .vram_cs   ( vram_cs                ),
        .cpu       ( cpu                    ),
        .vram_dout ( vram_dout              ),
        .prog      ( prog                   ),
        .gfx_we    ( prog_we[REG_TILE_GFX]  ),
        .raster    ( raster                 ),
        .prio      ( tile_prio              ),
        .pxl       ( tile_pxl               )
    );

    sprite_layer u_obj(
        .clk       ( clk                    ),
        .rst_n     ( rst_n                  ),
        .pxl_cen   ( pxl_cen                ),
        .flip      ( flip                   ),
        .objram_cs ( objram_cs              ),
        .gfx_we    ( prog_we[REG_OBJ_GFX]   ),
        .cpu       ( obj_cpu                ),
        .obj_dout  ( obj_dout               ),
        .prog      ( prog                   ),
        .raster    ( raster                 ),
        .pxl       ( obj_pxl                )
    );

    color_mixer u_mix(
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .pal_sel  ( pal_sel   ),
        .gfx_en   ( gfx_en    ),
        .tile_pxl ( tile_pxl  ),
        .obj_pxl  ( obj_pxl   ),
        .prio     ( tile_prio ),
        .raster   ( raster    ),
        .prog     ( prog      ),
        .pal_we   ( {prog_we[REG_PAL_B], prog_we[REG_PAL_RG]} ),
        .rgb      ( rgb       ),
        .lhbl     ( lhbl      ),
        .lvbl     ( lvbl      )
    );

endmodule

// ==== design/color_mixer.sv ====
`timescale 1ns/1ps

module color_mixer(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_cen,
    input  logic                       pal_sel,
    input  logic [1:0]                 gfx_en,    // Bit 0 tiles, bit 1 sprites
    input  mikie_video_pkg::pxl_t      tile_pxl,
    input  mikie_video_pkg::pxl_t      obj_pxl,
    input  logic                       prio,
    input  mikie_video_pkg::raster_t   raster,
    input  mikie_video_pkg::prog_bus_t prog,
    input  logic [1:0]                 pal_we,
    output mikie_video_pkg::rgb_t      rgb,
    output logic                       lhbl,
    output logic                       lvbl
);
    import mikie_video_pkg::*;

    logic [7:0]             pal_rg [64];  // Red high nibble, green low
    col_t                   pal_b  [64];
    pal_idx_t               idx;
    pxl_t                   tile_eff;
    pxl_t                   obj_eff;
    logic                   obj_win;
    logic [MIX_LATENCY-1:0] lhbl_dly;
    logic [MIX_LATENCY-1:0] lvbl_dly;

    always_ff @(posedge clk) begin
        if (pal_we[0]) begin
            pal_rg[prog.offset[5:0]] <= prog.data;
        end
        if (pal_we[1]) begin
            pal_b[prog.offset[5:0]] <= prog.data[3:0];
        end
    end

    assign tile_eff = gfx_en[0] ? tile_pxl : '0;
    assign obj_eff  = gfx_en[1] ? obj_pxl  : '0;
    // Tile priority only counts over an opaque tile pixel
    assign obj_win  = (obj_eff != '0) && !(prio && (tile_eff != '0));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx      <= '0;
            lhbl_dly <= '0;
            lvbl_dly <= '0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            idx      <= {pal_sel, obj_win, obj_win ? obj_eff : tile_eff};
            lhbl_dly <= {lhbl_dly[MIX_LATENCY-2:0], raster.lhbl};
            lvbl_dly <= {lvbl_dly[MIX_LATENCY-2:0], raster.lvbl};
            // Blanking from the stage that matches idx
            if (lhbl_dly[MIX_LATENCY-2] && lvbl_dly[MIX_LATENCY-2]) begin
                rgb <= '{
                    red:   pal_rg[idx][7:4],
                    green: pal_rg[idx][3:0],
                    blue:  pal_b[idx]
                };
            end else begin
                rgb <= '0;
            end
        end
    end

    assign lhbl = lhbl_dly[MIX_LATENCY-1];
    assign lvbl = lvbl_dly[MIX_LATENCY-1];

    a_blank_black: assert property (
        @(posedge clk) disable iff (!rst_n) !lhbl |-> (rgb == '0)
    );

endmodule

// ==== design/sprite_layer.sv ====
`timescale 1ns/1ps

module sprite_layer(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_cen,
    input  logic                       flip,
    input  logic                       objram_cs,
    input  logic                       gfx_we,
    input  mikie_video_pkg::cpu_bus_t  cpu,
    output logic [7:0]                 obj_dout,
    input  mikie_video_pkg::prog_bus_t prog,
    input  mikie_video_pkg::raster_t   raster,
    output mikie_video_pkg::pxl_t      pxl
);
    import mikie_video_pkg::*;

    // Internal byte order per sprite is y, attr, code, x
    logic [7:0]           objram [4*OBJ_COUNT];
    pxl_t                 gfx    [256];
    logic [7:0]           px;
    logic [7:0]           py;
    logic [OBJ_COUNT-1:0] hit;
    pxl_t                 obj_col [OBJ_COUNT];
    pxl_t                 win;

    assign px = {3'b000, raster.hdump[4:0] ^ {5{flip}}};
    assign py = {3'b000, raster.vdump[4:0] ^ {5{flip}}};

    always_ff @(posedge clk) begin
        if (objram_cs && !cpu.rnw) begin
            objram[cpu.addr[3:0]] <= cpu.dout;
        end
        if (objram_cs && cpu.rnw) begin
            obj_dout <= objram[cpu.addr[3:0]];
        end
        if (gfx_we) begin
            gfx[prog.offset] <= prog.data[3:0];
        end
    end

    for (genvar i = 0; i < OBJ_COUNT; i++) begin : g_obj
        logic [7:0] dx;
        logic [7:0] dy;
        logic [7:0] attr;
        logic [7:0] code;

        assign dy   = py - objram[4*i];
        assign attr = objram[4*i+1];
        assign code = objram[4*i+2];
        assign dx   = px - objram[4*i+3];

        assign obj_col[i] = gfx[{code[1:0], dy[2:0], dx[2:0]}];
        // Enabled, inside the 8x8 box and opaque here
        assign hit[i] = attr[0] && (dx < 8'd8) && (dy < 8'd8) && (obj_col[i] != '0);
    end

    // Walk downwards so the lowest-numbered hit is kept
    always_comb begin
        win = '0;
        for (int i = OBJ_COUNT - 1; i >= 0; i--) begin
            if (hit[i]) begin
                win = obj_col[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= win;
        end
    end

endmodule

// ==== design/tile_layer.sv ====
`timescale 1ns/1ps

module tile_layer(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pxl_cen,
    input  logic                       flip,
    input  logic                       vram_cs,
    input  mikie_video_pkg::cpu_bus_t  cpu,
    output logic [7:0]                 vram_dout,
    input  mikie_video_pkg::prog_bus_t prog,
    input  logic                       gfx_we,
    input  mikie_video_pkg::raster_t   raster,
    output logic                       prio,
    output mikie_video_pkg::pxl_t      pxl
);
    import mikie_video_pkg::*;

    logic [7:0] vram [16];      // 4x4 tile map
    pxl_t       gfx  [256];     // 4 codes of 8x8 nibbles
    logic [4:0] x;
    logic [4:0] y;
    logic [7:0] tile;
    logic [7:0] gfx_addr;

    // Inverting 5 bits gives 31-x, so flip costs nothing
    assign x = raster.hdump[4:0] ^ {5{flip}};
    assign y = raster.vdump[4:0] ^ {5{flip}};

    assign tile     = vram[{y[4:3], x[4:3]}];
    assign gfx_addr = {tile[1:0], y[2:0], x[2:0]}; // Code, row, column

    // CPU side of the tile map
    always_ff @(posedge clk) begin
        if (vram_cs && !cpu.rnw) begin
            vram[cpu.addr[3:0]] <= cpu.dout;
        end
        if (vram_cs && cpu.rnw) begin
            vram_dout <= vram[cpu.addr[3:0]]; // Held until next read
        end
    end

    // Graphics loaded from the program port
    always_ff @(posedge clk) begin
        if (gfx_we) begin
            gfx[prog.offset] <= prog.data[3:0]; // Low nibble only
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl  <= '0;
            prio <= 1'b0;
        end else if (pxl_cen) begin
            pxl  <= gfx[gfx_addr];
            prio <= tile[7];
        end
    end

    a_vram_addr: assert property (
        @(posedge clk) disable iff (!rst_n)
        (vram_cs && !cpu.rnw) |-> (cpu.addr < 11'd16)
    );

endmodule

// ==== design/video_timer.sv ====
`timescale 1ns/1ps

module video_timer(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pxl_cen,
    output mikie_video_pkg::raster_t raster,
    output logic                     hs,
    output logic                     vs
);
    import mikie_video_pkg::*;

    pos_t hcnt;
    pos_t vcnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (hcnt == pos_t'(H_TOTAL - 1)) begin
                hcnt <= '0;
                // Line done, step the vertical count
                if (vcnt == pos_t'(V_TOTAL - 1)) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 1'b1;
                end
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    assign raster = '{
        hdump: hcnt,
        vdump: vcnt,
        lhbl:  hcnt < H_ACTIVE,
        lvbl:  vcnt < V_ACTIVE
    };

    // Sync pulses sit inside the blanking intervals
    assign hs = (hcnt >= HS_START) && (hcnt < HS_START + SYNC_LEN);
    assign vs = (vcnt >= VS_START) && (vcnt < VS_START + SYNC_LEN);

    a_hcnt_range: assert property (
        @(posedge clk) disable iff (!rst_n) hcnt < H_TOTAL
    );

endmodule

// ==== design/mikie_video_pkg.sv ====
package mikie_video_pkg;

    // Raster geometry, scaled down
    localparam int H_TOTAL  = 48;
    localparam int H_ACTIVE = 32;
    localparam int V_TOTAL  = 40;
    localparam int V_ACTIVE = 32;
    localparam int HS_START = 36;
    localparam int VS_START = 34;
    localparam int SYNC_LEN = 4;    // Pulse width in pixels or lines

    // Program port regions, taken from prog_addr[10:8]
    localparam int REG_PAL_RG   = 0;
    localparam int REG_PAL_B    = 1;
    localparam int REG_TILE_GFX = 2;
    localparam int REG_OBJ_GFX  = 3;

    localparam int OBJ_COUNT   = 4;
    localparam int MIX_LATENCY = 3; // Timer position to RGB, in pxl_cen

    typedef logic [8:0] pos_t;
    typedef logic [3:0] pxl_t;      // 0 is transparent
    typedef logic [5:0] pal_idx_t;
    typedef logic [3:0] col_t;

    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  dout;          // CPU write data
        logic        rnw;
    } cpu_bus_t;

    typedef struct packed {
        logic [2:0] region;
        logic [7:0] offset;
        logic [7:0] data;
        logic       we;
    } prog_bus_t;

    typedef struct packed {
        pos_t hdump;
        pos_t vdump;
        logic lhbl;
        logic lvbl;
    } raster_t;

    typedef struct packed {
        col_t red;
        col_t green;
        col_t blue;
    } rgb_t;

endpackage
